// ==== source/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // Architectural widths
    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [7:0]  hw_int_t;

    // Software access port
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_wr_t;

    // Event from the pipeline, at most one of exception and ertn per cycle
    typedef struct packed {
        logic      exception;
        logic      ertn;
        logic      tlb_refill;
        ecode_t    ecode;
        logic      esubcode_bit;
        csr_data_t era;
        logic      llbit_set;
    } trap_event_t;

    typedef struct packed {
        csr_data_t crmd;
        csr_data_t prmd;
        csr_data_t ecfg;
        csr_data_t estat;
        csr_data_t era;
        csr_data_t eentry;
        csr_data_t llbctl;
    } trap_view_t;

    typedef struct packed {
        csr_data_t tcfg;
        csr_data_t tval;
    } timer_view_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;
    localparam csr_addr_t CSR_LLBCTL = 14'h060;

    localparam ecode_t ECODE_TLBR = 6'h3f;

    // Interrupt vector layout
    localparam int IS_TIMER_BIT = 11;
    localparam int_vec_t ECFG_LIE_MASK = 13'h1bff;

    localparam int MAX_SAVE = 4;

    // Field positions
    localparam int EENTRY_VA_LSB    = 6;
    localparam int TCFG_INITVAL_LSB = 2;

endpackage

`default_nettype wire

// ==== source/csr_trap_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_trap_regs (
    input  wire                  clk,
    input  wire                  aresetn,
    input  csr_pkg::csr_wr_t     wr,
    input  csr_pkg::trap_event_t trap_event,
    input  csr_pkg::hw_int_t     hw_int,
    input  wire                  timer_pending,
    output csr_pkg::trap_view_t  trap_view,
    output logic                 cpu_interrupt,
    output logic                 idle_over
);

    // CRMD
    csr_pkg::plv_t crmd_plv;
    logic          crmd_ie;
    logic          crmd_da;
    logic          crmd_pg;
    logic [1:0]    crmd_datf;
    logic [1:0]    crmd_datm;

    // PRMD
    csr_pkg::plv_t prmd_pplv;
    logic          prmd_pie;

    csr_pkg::int_vec_t  ecfg_lie;
    logic [1:0]         estat_is_soft;
    csr_pkg::ecode_t    estat_ecode;
    csr_pkg::esubcode_t estat_esubcode;
    csr_pkg::csr_data_t era_q;
    logic [31:csr_pkg::EENTRY_VA_LSB] eentry_va;

    // LLBCTL
    logic llb_rollb;
    logic llb_klo;

    csr_pkg::int_vec_t is_vec;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ecfg;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;
    logic wr_llbctl;
    logic exc_take;
    logic ertn_take;

    assign wr_crmd   = wr.en && (wr.addr == csr_pkg::CSR_CRMD);
    assign wr_prmd   = wr.en && (wr.addr == csr_pkg::CSR_PRMD);
    assign wr_ecfg   = wr.en && (wr.addr == csr_pkg::CSR_ECFG);
    assign wr_estat  = wr.en && (wr.addr == csr_pkg::CSR_ESTAT);
    assign wr_era    = wr.en && (wr.addr == csr_pkg::CSR_ERA);
    assign wr_eentry = wr.en && (wr.addr == csr_pkg::CSR_EENTRY);
    assign wr_llbctl = wr.en && (wr.addr == csr_pkg::CSR_LLBCTL);

    // ertn wins over a simultaneous exception
    assign ertn_take = trap_event.ertn;
    assign exc_take  = trap_event.exception && !trap_event.ertn;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (ertn_take) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
            // Returning from TLB refill goes back to paged mode
            if (estat_ecode == csr_pkg::ECODE_TLBR) begin
                crmd_da <= 1'b0;
                crmd_pg <= 1'b1;
            end
        end else if (exc_take) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            if (trap_event.tlb_refill) begin
                crmd_da <= 1'b1;
                crmd_pg <= 1'b0;
            end
        end else if (wr_crmd) begin
            crmd_plv  <= wr.wdata[1:0];
            crmd_ie   <= wr.wdata[2];
            crmd_datf <= wr.wdata[6:5];
            crmd_datm <= wr.wdata[8:7];
            // Only one of PG and DA may be set
            if (wr.wdata[4] ^ wr.wdata[3]) begin
                crmd_pg <= wr.wdata[4];
                crmd_da <= wr.wdata[3];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc_take) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= wr.wdata[1:0];
            prmd_pie  <= wr.wdata[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_is_soft  <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (exc_take) begin
            estat_ecode    <= trap_event.ecode;
            estat_esubcode <= (trap_event.ecode == '0) ? '0 :
                              csr_pkg::esubcode_t'(trap_event.esubcode_bit);
        end else if (wr_estat) begin
            estat_is_soft <= wr.wdata[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era_q <= '0;
        end else if (exc_take) begin
            era_q <= trap_event.era;
        end else if (wr_era) begin
            era_q <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie  <= '0;
            eentry_va <= '0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= wr.wdata[12:0] & csr_pkg::ECFG_LIE_MASK;
            end
            if (wr_eentry) begin
                eentry_va <= wr.wdata[31:csr_pkg::EENTRY_VA_LSB];
            end
        end
    end

    // A new LL sets ROLLB even on an ertn cycle
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            llb_rollb <= 1'b0;
            llb_klo   <= 1'b0;
        end else if (trap_event.llbit_set) begin
            llb_rollb <= 1'b1;
        end else if (ertn_take) begin
            llb_rollb <= llb_klo;
            llb_klo   <= 1'b0;
        end else if (wr_llbctl) begin
            if (wr.wdata[1]) begin
                llb_rollb <= 1'b0;
            end
            llb_klo <= wr.wdata[2];
        end
    end

    // IS vector with hardware lines passed straight through
    always_comb begin
        is_vec                        = '0;
        is_vec[1:0]                   = estat_is_soft;
        is_vec[9:2]                   = hw_int;
        is_vec[csr_pkg::IS_TIMER_BIT] = timer_pending;
    end

    assign cpu_interrupt = crmd_ie && (|(ecfg_lie & is_vec));
    assign idle_over     = |is_vec;

    assign trap_view.crmd   = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign trap_view.prmd   = {29'b0, prmd_pie, prmd_pplv};
    assign trap_view.ecfg   = {19'b0, ecfg_lie};
    assign trap_view.estat  = {1'b0, estat_esubcode, estat_ecode, 3'b0, is_vec};
    assign trap_view.era    = era_q;
    assign trap_view.eentry = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
    assign trap_view.llbctl = {29'b0, llb_klo, 1'b0, llb_rollb};

endmodule

`default_nettype wire

// ==== source/csr_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_timer (
    input  wire                  clk,
    input  wire                  aresetn,
    input  csr_pkg::csr_wr_t     wr,
    output csr_pkg::timer_view_t timer_view,
    output logic                 timer_pending
);

    csr_pkg::csr_data_t tcfg;
    csr_pkg::csr_data_t tval;
    csr_pkg::csr_data_t reload_val;
    logic               load;
    logic               expired;
    logic               tcfg_en;
    logic               tcfg_periodic;
    logic               wr_tcfg;
    logic               ticlr_clear;

    assign wr_tcfg     = wr.en && (wr.addr == csr_pkg::CSR_TCFG);
    assign ticlr_clear = wr.en && (wr.addr == csr_pkg::CSR_TICLR) && wr.wdata[0];

    assign tcfg_en       = tcfg[0];
    assign tcfg_periodic = tcfg[1];

    // One extra count so that INITVAL 0 still expires
    assign reload_val = {tcfg[31:csr_pkg::TCFG_INITVAL_LSB], 2'b01};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg <= '0;
            load <= 1'b0;
        end else begin
            load <= wr_tcfg;
            if (wr_tcfg) begin
                tcfg <= wr.wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval    <= '0;
            expired <= 1'b0;
        end else if (load) begin
            tval    <= reload_val;
            expired <= 1'b0;
        end else if (tval == '0) begin
            expired <= 1'b0;
            if (tcfg_en && tcfg_periodic) begin
                tval <= reload_val;
            end
        end else if (tcfg_en) begin
            tval    <= tval - 1'b1;
            expired <= (tval == 32'd1);
        end else begin
            expired <= 1'b0;
        end
    end

    // Clear has priority over a coincident expiry
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            timer_pending <= 1'b0;
        end else if (ticlr_clear) begin
            timer_pending <= 1'b0;
        end else if (expired) begin
            timer_pending <= 1'b1;
        end
    end

    assign timer_view.tcfg = tcfg;
    assign timer_view.tval = tval;

endmodule

`default_nettype wire

// ==== source/csr_save_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_save_bank #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                  clk,
    input  wire                                  aresetn,
    input  csr_pkg::csr_wr_t                     wr,
    output csr_pkg::csr_data_t [SAVE_COUNT-1:0]  save_words
);

    if (SAVE_COUNT < 1 || SAVE_COUNT > csr_pkg::MAX_SAVE) begin : g_bad_count
        $error("SAVE_COUNT out of range");
    end

    csr_pkg::csr_data_t [SAVE_COUNT-1:0] save_q;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            save_q <= '0;
        end else if (wr.en) begin
            for (int i = 0; i < SAVE_COUNT; i++) begin
                if (wr.addr == csr_pkg::csr_addr_t'(csr_pkg::CSR_SAVE0 + i)) begin
                    save_q[i] <= wr.wdata;
                end
            end
        end
    end

    assign save_words = save_q;

endmodule

`default_nettype wire

// ==== source/csr_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_pkg::csr_addr_t                  raddr,
    input  csr_pkg::trap_view_t                 trap_view,
    input  csr_pkg::timer_view_t                timer_view,
    input  csr_pkg::csr_data_t [SAVE_COUNT-1:0] save_words,
    output csr_pkg::csr_data_t                  rdata
);

    csr_pkg::csr_data_t save_rdata;

    // Unimplemented SAVE numbers fall through as zero
    always_comb begin
        save_rdata = '0;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (raddr == csr_pkg::csr_addr_t'(csr_pkg::CSR_SAVE0 + i)) begin
                save_rdata = save_words[i];
            end
        end
    end

    always_comb begin
        case (raddr)
            csr_pkg::CSR_CRMD: begin
                rdata = trap_view.crmd;
            end
            csr_pkg::CSR_PRMD: begin
                rdata = trap_view.prmd;
            end
            csr_pkg::CSR_ECFG: begin
                rdata = trap_view.ecfg;
            end
            csr_pkg::CSR_ESTAT: begin
                rdata = trap_view.estat;
            end
            csr_pkg::CSR_ERA: begin
                rdata = trap_view.era;
            end
            csr_pkg::CSR_EENTRY: begin
                rdata = trap_view.eentry;
            end
            csr_pkg::CSR_LLBCTL: begin
                rdata = trap_view.llbctl;
            end
            csr_pkg::CSR_TCFG: begin
                rdata = timer_view.tcfg;
            end
            csr_pkg::CSR_TVAL: begin
                rdata = timer_view.tval;
            end
            // TICLR and unknown numbers read as zero here
            default: begin
                rdata = save_rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/csr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                  clk,
    input  wire                  aresetn,
    input  csr_pkg::csr_wr_t     wr,
    input  csr_pkg::csr_addr_t   raddr,
    input  csr_pkg::trap_event_t trap_event,
    input  csr_pkg::hw_int_t     hw_int,
    output csr_pkg::csr_data_t   rdata,
    output csr_pkg::csr_data_t   crmd,
    output csr_pkg::csr_data_t   era,
    output csr_pkg::csr_data_t   eentry,
    output logic                 cpu_interrupt,
    output logic                 idle_over,
    output logic                 llbit
);

    csr_pkg::trap_view_t                 trap_view;
    csr_pkg::timer_view_t                timer_view;
    csr_pkg::csr_data_t [SAVE_COUNT-1:0] save_words;
    logic                                timer_pending;

    csr_trap_regs trap_regs_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .trap_event    (trap_event),
        .hw_int        (hw_int),
        .timer_pending (timer_pending),
        .trap_view     (trap_view),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over)
    );

    csr_timer timer_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .timer_view    (timer_view),
        .timer_pending (timer_pending)
    );

    csr_save_bank #(
        .SAVE_COUNT (SAVE_COUNT)
    ) save_bank_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .wr         (wr),
        .save_words (save_words)
    );

    csr_read_mux #(
        .SAVE_COUNT (SAVE_COUNT)
    ) read_mux_i (
        .raddr      (raddr),
        .trap_view  (trap_view),
        .timer_view (timer_view),
        .save_words (save_words),
        .rdata      (rdata)
    );

    assign crmd   = trap_view.crmd;
    assign era    = trap_view.era;
    assign eentry = trap_view.eentry;
    // ROLLB doubles as the LL bit
    assign llbit  = trap_view.llbctl[0];

endmodule

`default_nettype wire

// ==== dv/csr_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_asserts (
    input wire                clk,
    input wire                aresetn,
    input csr_pkg::csr_addr_t raddr,
    input csr_pkg::csr_data_t rdata,
    input csr_pkg::csr_data_t crmd,
    input wire                cpu_interrupt
);

    int error_count = 0;

    // CRMD bit 4 is PG and bit 3 is DA
    pg_da_exclusive: assert property (@(posedge clk) disable iff (!aresetn)
        crmd[4] ^ crmd[3])
        else begin
            $error("CRMD shows PG and DA both set or both clear");
            error_count++;
        end

    irq_needs_ie: assert property (@(posedge clk) disable iff (!aresetn)
        cpu_interrupt |-> crmd[2])
        else begin
            $error("cpu_interrupt raised with CRMD.IE clear");
            error_count++;
        end

    ticlr_reads_zero: assert property (@(posedge clk) disable iff (!aresetn)
        (raddr == csr_pkg::CSR_TICLR) |-> (rdata == '0))
        else begin
            $error("TICLR read returned a nonzero word");
            error_count++;
        end

endmodule

bind csr_top csr_asserts csr_asserts_i (
    .clk           (clk),
    .aresetn       (aresetn),
    .raddr         (raddr),
    .rdata         (rdata),
    .crmd          (crmd),
    .cpu_interrupt (cpu_interrupt)
);

`default_nettype wire

// ==== dv/csr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_tb;

    localparam int MAX_RECORDS = 128;
    localparam int CLK_HALF    = 2;
    localparam int OP_END      = 8'hff;

    logic                 clk;
    logic                 aresetn;
    csr_pkg::csr_wr_t     wr;
    csr_pkg::csr_addr_t   raddr;
    csr_pkg::trap_event_t trap_event;
    csr_pkg::hw_int_t     hw_int;
    csr_pkg::csr_data_t   rdata;
    csr_pkg::csr_data_t   crmd;
    csr_pkg::csr_data_t   era;
    csr_pkg::csr_data_t   eentry;
    logic                 cpu_interrupt;
    logic                 idle_over;
    logic                 llbit;

    // Each record is three words of op, argument and data or expected value
    logic [31:0] vec_mem [0:3*MAX_RECORDS-1];
    int          record_count;
    int          max_timer_wait;
    int          cycle_count = 0;
    int          tcfg_edge;
    logic        limit_ready;

    csr_top #(
        .SAVE_COUNT (4)
    ) csr_top_i (
        .clk           (clk),
        .aresetn       (aresetn),
        .wr            (wr),
        .raddr         (raddr),
        .trap_event    (trap_event),
        .hw_int        (hw_int),
        .rdata         (rdata),
        .crmd          (crmd),
        .era           (era),
        .eentry        (eentry),
        .cpu_interrupt (cpu_interrupt),
        .idle_over     (idle_over),
        .llbit         (llbit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_vectors();
        int          idx;
        logic [31:0] op;
        int          wait_len;
        $readmemh("dv/csr_vectors.txt", vec_mem);
        record_count   = -1;
        max_timer_wait = 0;
        for (idx = 0; idx < MAX_RECORDS && record_count < 0; idx++) begin
            op = vec_mem[3*idx];
            if ($isunknown(op)) begin
                abort_run("vector file ended without an end record");
            end else if (op == OP_END) begin
                record_count = idx;
            end else if (op == 32'h8) begin
                wait_len = 4 * int'(vec_mem[3*idx+1]) + 6;
                if (wait_len > max_timer_wait) begin
                    max_timer_wait = wait_len;
                end
            end
        end
        if (record_count < 0) begin
            abort_run("vector file holds too many records");
        end
    endtask

    // Pending must show between 4K and 4K+6 cycles after the TCFG write
    task automatic wait_timer(input logic [31:0] initval);
        int elapsed;
        int window_end;
        window_end = 4 * int'(initval) + 6;
        raddr      = csr_pkg::CSR_ESTAT;
        #1;
        elapsed = cycle_count - tcfg_edge;
        while (rdata[csr_pkg::IS_TIMER_BIT] !== 1'b1 && elapsed < window_end) begin
            @(negedge clk);
            #1;
            elapsed = cycle_count - tcfg_edge;
        end
        check_value("timer_pending", rdata[csr_pkg::IS_TIMER_BIT], 32'd1);
        check_value("timer_pending_early", elapsed < 4 * int'(initval), 32'd0);
    endtask

    task automatic run_record(input logic [7:0] op, input logic [31:0] arg_x,
                              input logic [31:0] arg_y);
        case (op)
            8'h01: begin
                wr.en    = 1'b1;
                wr.addr  = arg_x[13:0];
                wr.wdata = arg_y;
                if (wr.addr == csr_pkg::CSR_TCFG) begin
                    tcfg_edge = cycle_count + 1;
                end
            end
            8'h02: begin
                raddr = arg_x[13:0];
                #1;
                check_value($sformatf("rdata[0x%03h]", raddr), rdata, arg_y);
                // Mirrored registers also appear on their own ports
                case (raddr)
                    csr_pkg::CSR_CRMD: begin
                        check_value("crmd", crmd, arg_y);
                    end
                    csr_pkg::CSR_ERA: begin
                        check_value("era", era, arg_y);
                    end
                    csr_pkg::CSR_EENTRY: begin
                        check_value("eentry", eentry, arg_y);
                    end
                    default: begin
                    end
                endcase
            end
            8'h03: begin
                trap_event.exception    = 1'b1;
                trap_event.tlb_refill   = arg_x[12];
                trap_event.esubcode_bit = arg_x[8];
                trap_event.ecode        = arg_x[5:0];
                trap_event.era          = arg_y;
            end
            8'h04: trap_event.ertn = 1'b1;
            8'h05: trap_event.llbit_set = 1'b1;
            8'h06: hw_int = arg_y[7:0];
            8'h07: begin
                #1;
                check_value("cpu_interrupt", cpu_interrupt, arg_y[8]);
                check_value("idle_over", idle_over, arg_y[4]);
                check_value("llbit", llbit, arg_y[0]);
            end
            8'h08: wait_timer(arg_x);
            default: abort_run($sformatf("unknown vector operation 0x%02h", op));
        endcase
    endtask

    initial begin
        int idx;
        aresetn     = 1'b0;
        wr          = '0;
        raddr       = '0;
        trap_event  = '0;
        hw_int      = '0;
        tcfg_edge   = 0;
        limit_ready = 1'b0;
        load_vectors();
        limit_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;
        for (idx = 0; idx < record_count; idx++) begin
            @(negedge clk);
            wr         = '0;
            trap_event = '0;
            run_record(vec_mem[3*idx][7:0], vec_mem[3*idx+1], vec_mem[3*idx+2]);
        end
        @(negedge clk);
        wr         = '0;
        trap_event = '0;
        if (csr_top_i.csr_asserts_i.error_count != 0) begin
            abort_run($sformatf("bound assertions failed %0d times",
                                csr_top_i.csr_asserts_i.error_count));
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    initial begin
        int limit;
        wait (limit_ready);
        limit = record_count * 50 + max_timer_wait;
        repeat (limit) @(posedge clk);
        abort_run("watchdog expired before all vectors were applied");
    end

endmodule

`default_nettype wire

// ==== dv/csr_vectors.txt ====
// Columns: op, address or argument, data or expected value, all hex; op ff ends the list
// op 1 write, 2 read, 3 exception (refill<<12|subbit<<8|ecode), 4 ertn, 5 llbit set,
// 6 hw_int, 7 expect {cpu_interrupt, idle_over, llbit} nibbles, 8 timer wait (INITVAL)
// Reset values
2 000 00000008
2 001 00000000
2 005 00000000
2 006 00000000
2 030 00000000
2 042 00000000
7 0 000
// Write masks
1 004 ffffffff
2 004 00001bff
1 004 00000000
1 00c ffffffff
2 00c ffffffc0
1 001 ffffffff
2 001 00000007
1 001 00000000
1 005 ffffffff
2 005 00000003
7 0 010
1 005 00000000
1 033 12345678
2 033 12345678
1 000 ffffffff
2 000 000001ef
// Exception with TLB refill, then ertn
3 113f 1c000100
2 001 00000007
2 000 000001e8
2 006 1c000100
2 005 007f0000
4 0 0
2 000 000001f7
// Interrupts
1 000 00000010
2 000 00000010
6 0 04
7 0 010
1 004 00000010
7 0 010
1 000 00000014
7 0 110
6 0 00
7 0 000
1 005 00000001
7 0 010
1 004 00000001
7 0 110
1 005 00000000
7 0 000
// One-shot timer
1 041 0000000d
8 3 0
2 005 007f0800
1 044 00000001
2 005 007f0000
2 042 00000000
2 044 00000000
2 005 007f0000
// Load-linked bit
5 0 0
7 0 001
1 060 00000002
7 0 000
5 0 0
1 060 00000004
2 060 00000005
4 0 0
2 060 00000001
7 0 001
ff 0 0

// ==== filelist.f ====
source/csr_pkg.sv
source/csr_trap_regs.sv
source/csr_timer.sv
source/csr_save_bank.sv
source/csr_read_mux.sv
source/csr_top.sv
dv/csr_asserts.sv
dv/csr_tb.sv
